//--- Bender.yml
package:
  name: rv_exec

sources:
  - rv_isa_pkg.sv
  - exec_bus_pkg.sv
  - regfile_if.sv
  - int_regfile.sv
  - int_alu.sv
  - exec_sequencer.sv
  - perf_counters.sv
  - rv_exec_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - rv_exec_tb.sv

//--- all.f
rv_isa_pkg.sv
exec_bus_pkg.sv
regfile_if.sv
int_regfile.sv
int_alu.sv
exec_sequencer.sv
perf_counters.sv
rv_exec_top.sv
tb_clock_gen.sv
rv_exec_tb.sv

//--- exec_bus_pkg.sv
/*
 * Host-side definitions of the execute slice.
 * Wishbone word address map and the sequencer state encoding.
 */
package exec_bus_pkg;

	typedef logic [6:0] adr_t;  // Wishbone word address.

	localparam adr_t adr_reg_base = 7'h00;  // x0..x31 at 0x00..0x1F.
	localparam adr_t adr_instr    = 7'h20;  // Write executes one instruction.
	localparam adr_t adr_retired  = 7'h21;  // Write clears both counters.
	localparam adr_t adr_cycles   = 7'h22;

	typedef enum logic [1:0] {
		idle,
		exec,       // Operands read, ALU result captured.
		writeback,  // rd written, ack or err out.
		respond     // Single-cycle host access answered.
	} seq_state_e;

endpackage

//--- exec_sequencer.sv
/*
 * Wishbone classic slave and instruction sequencer of the execute slice.
 * Host accesses answer after one cycle; an instruction write runs through
 * exec and writeback and answers after two.
 */
`timescale 1ns/1ps

module exec_sequencer #(
	parameter int xlen = 64
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  exec_bus_pkg::adr_t  wb_adr,
	input  logic [xlen-1:0]     wb_dat_i,
	output logic [xlen-1:0]     wb_dat_o,
	output logic                wb_ack,
	output logic                wb_err,
	regfile_if.ctrl             rf,
	output rv_isa_pkg::instr_u  instr,
	input  logic [xlen-1:0]     alu_result,
	input  logic                alu_illegal,
	output logic                retire,
	output logic                clear,
	input  logic [xlen-1:0]     retired,
	input  logic [xlen-1:0]     cycles
);

	exec_bus_pkg::seq_state_e state;
	rv_isa_pkg::reg_addr_t    wr_addr_q;
	logic [xlen-1:0]          wr_data_q;
	logic                     we_q;
	logic [xlen-1:0]          rd_mux;
	logic                     accept;
	logic                     is_reg;
	logic                     is_instr;
	logic                     is_retired;
	logic                     is_cycles;
	logic                     single_ok;

	assign accept     = state == exec_bus_pkg::idle && wb_cyc && wb_stb;
	assign is_reg     = (wb_adr & ~7'h1F) == exec_bus_pkg::adr_reg_base;
	assign is_instr   = wb_adr == exec_bus_pkg::adr_instr;
	assign is_retired = wb_adr == exec_bus_pkg::adr_retired;
	assign is_cycles  = wb_adr == exec_bus_pkg::adr_cycles;
	// Everything but a write to the cycle counter or an unmapped address.
	assign single_ok  = is_reg || is_instr || is_retired || (is_cycles && !wb_we);

	always_comb begin
		rd_mux = '0;
		if (is_reg) begin
			rd_mux = rf.dbg_data;
		end else if (is_instr) begin
			rd_mux[31:0] = instr;  // Last instruction issued.
		end else if (is_retired) begin
			rd_mux = retired;
		end else if (is_cycles) begin
			rd_mux = cycles;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= exec_bus_pkg::idle;
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
			we_q   <= 1'b0;
			retire <= 1'b0;
			clear  <= 1'b0;
		end else begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
			we_q   <= 1'b0;
			retire <= 1'b0;
			clear  <= 1'b0;
			case (state)
				exec_bus_pkg::idle: begin
					if (accept && is_instr && wb_we) begin
						state <= exec_bus_pkg::exec;
					end else if (accept) begin
						state  <= exec_bus_pkg::respond;
						wb_ack <= single_ok;
						wb_err <= !single_ok;
						we_q   <= is_reg && wb_we;  // Commits as ack drops.
						clear  <= is_retired && wb_we;
					end
				end
				exec_bus_pkg::exec: begin
					state  <= exec_bus_pkg::writeback;
					wb_ack <= !alu_illegal;
					wb_err <= alu_illegal;
					we_q   <= !alu_illegal;
					retire <= !alu_illegal;
				end
				default: state <= exec_bus_pkg::idle;  // Writeback and respond.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			wr_addr_q <= wb_adr[4:0];
			wr_data_q <= wb_dat_i;
			wb_dat_o  <= rd_mux;
			if (is_instr && wb_we) begin
				instr <= wb_dat_i[31:0];
			end
		end else if (state == exec_bus_pkg::exec) begin
			wr_addr_q <= instr.r.rd;
			wr_data_q <= alu_result;
		end
	end

	assign rf.waddr    = wr_addr_q;
	assign rf.wdata    = wr_data_q;
	assign rf.we       = we_q;
	assign rf.raddr1   = instr.r.rs1;
	assign rf.raddr2   = instr.r.rs2;
	assign rf.re1      = state == exec_bus_pkg::exec;
	assign rf.re2      = state == exec_bus_pkg::exec;
	assign rf.dbg_addr = wb_adr[4:0];
	assign rf.dbg_re   = accept && is_reg && !wb_we;

	a_ack_err_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(wb_ack && wb_err));
	a_resp_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_ack || wb_err) |-> wb_cyc);

endmodule

//--- int_alu.sv
/*
 * Combinational integer ALU for the OP and OP-IMM groups.
 * Decodes the instruction union, picks rs2 or the immediate as second
 * operand, and flags any encoding outside the supported set.
 */
`timescale 1ns/1ps

module int_alu #(
	parameter int xlen = 64
) (
	input  rv_isa_pkg::instr_u instr,
	input  logic [xlen-1:0]    rs1_val,
	input  logic [xlen-1:0]    rs2_val,
	output logic [xlen-1:0]    result,
	output logic               illegal
);

	localparam int shw = $clog2(xlen);  // 6 for RV64, 5 for RV32.

	logic            is_reg;
	logic            is_imm;
	logic [xlen-1:0] op_b;
	logic            alt;
	logic [shw-1:0]  shamt;
	logic            f7_zero;
	logic            f7_alt_ok;
	logic            sh_hi_ok;

	assign is_reg    = instr.r.opcode == rv_isa_pkg::op_reg;
	assign is_imm    = instr.r.opcode == rv_isa_pkg::op_imm;
	assign op_b      = is_reg ? rs2_val : {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
	assign alt       = is_reg ? instr.r.funct7[5] : instr.i.imm[10];  // SUB or SRA.
	assign shamt     = op_b[shw-1:0];
	assign f7_zero   = instr.r.funct7 == 7'b0000000;
	assign f7_alt_ok = f7_zero || instr.r.funct7 == 7'b0100000;
	// Immediate bits above shamt must be clear, apart from the SRA bit.
	assign sh_hi_ok  = (11'({instr.i.imm[11], instr.i.imm[9:0]}) >> shw) == '0;

	always_comb begin
		result  = '0;
		illegal = !(is_reg || is_imm);
		case (instr.r.funct3)
			rv_isa_pkg::f3_add_sub: begin
				result = (is_reg && alt) ? rs1_val - op_b : rs1_val + op_b;
				illegal |= is_reg && !f7_alt_ok;
			end
			rv_isa_pkg::f3_sll: begin
				result = rs1_val << shamt;
				illegal |= is_reg ? !f7_zero : !(sh_hi_ok && !instr.i.imm[10]);
			end
			rv_isa_pkg::f3_slt: begin
				result = xlen'($signed(rs1_val) < $signed(op_b));
				illegal |= is_reg && !f7_zero;
			end
			rv_isa_pkg::f3_sltu: begin
				result = xlen'(rs1_val < op_b);
				illegal |= is_reg && !f7_zero;
			end
			rv_isa_pkg::f3_xor: begin
				result = rs1_val ^ op_b;
				illegal |= is_reg && !f7_zero;
			end
			rv_isa_pkg::f3_srl_sra: begin
				result = alt ? xlen'($signed(rs1_val) >>> shamt) : rs1_val >> shamt;
				illegal |= is_reg ? !f7_alt_ok : !sh_hi_ok;
			end
			rv_isa_pkg::f3_or: begin
				result = rs1_val | op_b;
				illegal |= is_reg && !f7_zero;
			end
			default: begin  // AND.
				result = rs1_val & op_b;
				illegal |= is_reg && !f7_zero;
			end
		endcase
	end

endmodule

//--- int_regfile.sv
/*
 * 32 general-purpose integer registers, x0 reads as zero.
 * One write port, two operand read ports and one host read port, all
 * combinational reads with write-through bypass of the current write.
 */
`timescale 1ns/1ps

module int_regfile #(
	parameter int xlen = 64
) (
	input logic   clk,
	input logic   arst_n,
	regfile_if.rf rf
);

	logic [xlen-1:0] regs [0:31];

	// Disabled port reads zero, a same-cycle write to the index is forwarded.
	function automatic logic [xlen-1:0] read_port(
		input rv_isa_pkg::reg_addr_t addr,
		input logic                  en
	);
		logic [xlen-1:0] val;
		if (!en) begin
			val = '0;
		end else if (rf.we && rf.waddr == addr && addr != '0) begin
			val = rf.wdata;  // Bypass.
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.we && rf.waddr != '0) begin
			regs[rf.waddr] <= rf.wdata;  // Writes to x0 are dropped.
		end
	end

	assign rf.rdata1   = read_port(rf.raddr1, rf.re1);
	assign rf.rdata2   = read_port(rf.raddr2, rf.re2);
	assign rf.dbg_data = read_port(rf.dbg_addr, rf.dbg_re);

	// x0 stays zero on every port, even while it is the write target.
	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		((rf.re1 && rf.raddr1 == '0) |-> rf.rdata1 == '0) and
		((rf.re2 && rf.raddr2 == '0) |-> rf.rdata2 == '0) and
		((rf.dbg_re && rf.dbg_addr == '0) |-> rf.dbg_data == '0));

endmodule

//--- perf_counters.sv
/*
 * Cycle and retired-instruction counters read by the host.
 * A clear pulse zeroes both and wins over counting.
 */
`timescale 1ns/1ps

module perf_counters #(
	parameter int xlen = 64
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            retire,
	input  logic            clear,
	output logic [xlen-1:0] retired,
	output logic [xlen-1:0] cycles
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retired <= '0;
			cycles  <= '0;
		end else if (clear) begin
			retired <= '0;
			cycles  <= '0;
		end else begin
			cycles <= cycles + 1'b1;  // Free running.
			if (retire) begin
				retired <= retired + 1'b1;
			end
		end
	end

endmodule

//--- regfile_if.sv
/*
 * Port bundle of the integer register file.
 * The sequencer drives it through ctrl, the register file serves it through rf.
 */
`timescale 1ns/1ps

interface regfile_if #(
	parameter int xlen = 64
) ();

	rv_isa_pkg::reg_addr_t waddr;
	logic [xlen-1:0]       wdata;
	logic                  we;

	rv_isa_pkg::reg_addr_t raddr1;
	logic                  re1;
	logic [xlen-1:0]       rdata1;
	rv_isa_pkg::reg_addr_t raddr2;
	logic                  re2;
	logic [xlen-1:0]       rdata2;

	rv_isa_pkg::reg_addr_t dbg_addr;  // Host read port.
	logic                  dbg_re;
	logic [xlen-1:0]       dbg_data;

	modport ctrl (
		output waddr, wdata, we, raddr1, re1, raddr2, re2, dbg_addr, dbg_re,
		input  rdata1, rdata2, dbg_data
	);

	modport rf (
		input  waddr, wdata, we, raddr1, re1, raddr2, re2, dbg_addr, dbg_re,
		output rdata1, rdata2, dbg_data
	);

endinterface

//--- rv_exec_tb.sv
/*
 * Testbench of the RISC-V execute slice.
 * Reads Wishbone operations from rv_exec_vectors.txt, runs them on the DUT
 * and checks responses against expected values and a shadow register model.
 */
`timescale 1ns/1ps

module rv_exec_tb;

	localparam int xlen          = 64;
	localparam int clk_period_ns = 10;
	localparam int reset_cycles  = 8;
	localparam int cycles_per_op = 20;  // Watchdog budget per operation.
	localparam int resp_limit    = 8;   // Cycles to wait for ack or err.

	logic               clk;
	logic               arst_n;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	exec_bus_pkg::adr_t wb_adr;
	logic [xlen-1:0]    wb_dat_i;
	logic [xlen-1:0]    wb_dat_o;
	logic               wb_ack;
	logic               wb_err;

	string              v_name[$];
	byte                v_op[$];
	exec_bus_pkg::adr_t v_adr[$];
	logic [63:0]        v_dat[$];
	bit                 v_rand[$];
	bit                 v_has_dat[$];
	byte                v_mode[$];
	logic [63:0]        v_exp[$];

	logic [63:0] model_regs [0:31];
	logic [63:0] model_retired;
	logic [63:0] last_cycles;
	logic [31:0] lfsr_state;
	bit          vectors_ready;
	bit          loaded_ok;
	string       cur_name;
	int          cur_errors;
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;

	tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) i_tb_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	rv_exec_top #(.xlen(xlen)) i_rv_exec_top (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.wb_err   (wb_err)
	);

	// x^32 + x^22 + x^2 + x + 1, maximal length.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_random(output logic [63:0] v);
		v = '0;
		for (int b = 0; b < 64; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v          = {v[62:0], lfsr_state[0]};
		end
	endtask

	task automatic count_error();
		errors++;
		cur_errors++;
	endtask

	task automatic load_vectors(output bit ok);
		int          fd;
		int          lo;
		int          hi;
		string       line;
		string       name_s;
		string       op_s;
		string       adr_s;
		string       dat_s;
		string       exp_s;
		logic [63:0] dat;
		logic [63:0] expv;
		byte         mode;
		ok = 1'b1;
		fd = $fopen("rv_exec_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file rv_exec_vectors.txt");
			ok = 1'b0;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				if ($sscanf(line, "%s %s %s %s %s", name_s, op_s, adr_s, dat_s, exp_s) != 5) begin
					$display("Malformed vector line: %s", line);
					ok = 1'b0;
					continue;
				end
				if ($sscanf(adr_s, "%h-%h", lo, hi) != 2) begin
					hi = lo;  // Single address.
				end
				dat  = '0;
				expv = '0;
				mode = "v";
				if (dat_s != "r" && dat_s != "-") begin
					void'($sscanf(dat_s, "%h", dat));
				end
				if (exp_s == "m" || exp_s == "g" || exp_s == "-") begin
					mode = exp_s.getc(0);
				end else begin
					void'($sscanf(exp_s, "%h", expv));
				end
				for (int a = lo; a <= hi; a++) begin
					v_name.push_back(name_s);
					v_op.push_back(op_s.getc(0));
					v_adr.push_back(a[6:0]);
					v_dat.push_back(dat);
					v_rand.push_back(dat_s == "r");
					v_has_dat.push_back(dat_s != "-");
					v_mode.push_back(mode);
					v_exp.push_back(expv);
				end
			end
			$fclose(fd);
			if (v_name.size() == 0) begin
				$display("The vector file holds no operations");
				ok = 1'b0;
			end
		end
	endtask

	// One classic cycle; inputs change only on rising edges.
	task automatic wb_transfer(
		input  logic               we,
		input  exec_bus_pkg::adr_t adr,
		input  logic [63:0]        dat,
		output logic [63:0]        rdata,
		output logic               ack,
		output logic               err
	);
		int waited;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_i <= dat;
		ack      = 1'b0;
		err      = 1'b0;
		rdata    = '0;
		waited   = 0;
		while (!ack && !err && waited < resp_limit) begin
			@(posedge clk);
			ack   = wb_ack;  // Flop outputs, sampled before they update.
			err   = wb_err;
			rdata = wb_dat_o;
			waited++;
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	// Reference behavior of OP and OP-IMM from the RV64I definition.
	task automatic ref_execute(input logic [31:0] ins, output logic [63:0] res, output logic bad);
		logic [6:0]         opcode;
		logic [2:0]         f3;
		logic [6:0]         f7;
		logic [63:0]        a;
		logic [63:0]        b;
		logic signed [63:0] sa;
		logic [5:0]         sh;
		logic               is_op;
		opcode = ins[6:0];
		f3     = ins[14:12];
		f7     = ins[31:25];
		is_op  = opcode == 7'h33;
		a      = model_regs[ins[19:15]];
		b      = is_op ? model_regs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
		sa     = a;
		sh     = b[5:0];
		res    = '0;
		bad    = 1'b0;
		if (!is_op && opcode != 7'h13) begin
			bad = 1'b1;
		end else if (is_op && !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) begin
			bad = 1'b1;
		end else if (!is_op && f3 == 3'd1 && ins[31:26] != 6'h00) begin
			bad = 1'b1;
		end else if (!is_op && f3 == 3'd5 && ins[31:26] != 6'h00 && ins[31:26] != 6'h10) begin
			bad = 1'b1;
		end else begin
			case (f3)
				3'd0: res = (is_op && f7[5]) ? a - b : a + b;
				3'd1: res = a << sh;
				3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
				3'd3: res = (a < b) ? 64'd1 : 64'd0;
				3'd4: res = a ^ b;
				3'd5: res = ins[30] ? 64'(sa >>> sh) : a >> sh;
				3'd6: res = a | b;
				default: res = a & b;
			endcase
		end
	endtask

	task automatic update_model(
		input logic               is_write,
		input exec_bus_pkg::adr_t adr,
		input logic [63:0]        wdata,
		input logic [63:0]        result
	);
		if (is_write && adr < 7'd32) begin
			if (adr != 7'd0) begin
				model_regs[adr[4:0]] = wdata;
			end
		end else if (is_write && adr == exec_bus_pkg::adr_instr) begin
			if (wdata[11:7] != 5'd0) begin
				model_regs[wdata[11:7]] = result;
			end
			model_retired++;
		end else if (is_write && adr == exec_bus_pkg::adr_retired) begin
			model_retired = '0;  // Clear.
		end
	endtask

	task automatic check_read(input int i, input logic [63:0] rdata);
		logic [63:0] expected;
		logic        compare;
		compare  = 1'b1;
		expected = v_exp[i];
		if (v_mode[i] == "m") begin
			expected = (v_adr[i] == exec_bus_pkg::adr_retired) ?
				model_retired : model_regs[v_adr[i][4:0]];
		end else if (v_mode[i] == "g") begin
			compare = 1'b0;
			checks++;
			assert (rdata > last_cycles) else begin
				$display("FAILED at %0t: wb_dat_o (cycles, test %s) expected above %h, got %h",
					$time, v_name[i], last_cycles, rdata);
				count_error();
			end
		end else if (v_mode[i] == "-") begin
			compare = 1'b0;
		end
		if (v_adr[i] == exec_bus_pkg::adr_cycles) begin
			last_cycles = rdata;
		end
		if (compare) begin
			checks++;
			assert (rdata === expected) else begin
				$display("FAILED at %0t: wb_dat_o (adr 0x%h, test %s) expected %h, got %h",
					$time, v_adr[i], v_name[i], expected, rdata);
				count_error();
			end
		end
	endtask

	task automatic run_vector(input int i);
		logic [63:0] wdata;
		logic [63:0] rdata;
		logic [63:0] result;
		logic        is_write;
		logic        want_err;
		logic        bad;
		logic        got_ack;
		logic        got_err;
		wdata = v_dat[i];
		if (v_rand[i]) begin
			draw_random(wdata);
		end
		is_write = v_op[i] == "w" || (v_op[i] == "e" && v_has_dat[i]);
		want_err = v_op[i] == "e";
		result   = '0;
		bad      = 1'b0;
		if (is_write && v_adr[i] == exec_bus_pkg::adr_instr) begin
			ref_execute(wdata[31:0], result, bad);
			checks++;
			assert (bad == want_err) else begin
				$display("Test %s: the reference model and the vector disagree on instruction %h",
					v_name[i], wdata[31:0]);
				count_error();
			end
		end
		wb_transfer(is_write, v_adr[i], wdata, rdata, got_ack, got_err);
		checks++;
		assert (got_ack || got_err) else begin
			$display("Test %s: no response to address 0x%h within %0d cycles",
				v_name[i], v_adr[i], resp_limit);
			count_error();
		end
		if (got_ack || got_err) begin
			checks++;
			assert (got_err == want_err) else begin
				$display("FAILED at %0t: wb_err (adr 0x%h, test %s) expected %b, got %b",
					$time, v_adr[i], v_name[i], want_err, got_err);
				count_error();
			end
		end
		if (got_ack) begin
			update_model(is_write, v_adr[i], wdata, result);
			if (v_op[i] == "r") begin
				check_read(i, rdata);
			end
		end
	endtask

	task automatic close_test();
		tests_run++;
		if (cur_errors != 0) begin
			tests_failed++;
		end
		$display("Test %-10s %s", cur_name, (cur_errors == 0) ? "passed" : "failed");
	endtask

	initial begin
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_i      = '0;
		model_retired = '0;
		last_cycles   = '0;
		lfsr_state    = 32'd90872;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		cur_errors    = 0;
		cur_name      = "";
		vectors_ready = 1'b0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		load_vectors(loaded_ok);
		vectors_ready = 1'b1;
		if (!loaded_ok) begin
			$display("Some tests failed");
		end else begin
			wait (arst_n === 1'b1);
			for (int i = 0; i < v_name.size(); i++) begin
				if (v_name[i] != cur_name) begin
					if (cur_name != "") begin
						close_test();
					end
					cur_name   = v_name[i];
					cur_errors = 0;
				end
				run_vector(i);
			end
			close_test();
			$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
				tests_run, tests_failed, checks, errors);
			if (errors == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
		end
		$finish;
	end

	// Watchdog, sized from the number of operations.
	initial begin
		int limit_ns;
		wait (vectors_ready);
		limit_ns = (v_name.size() * cycles_per_op + reset_cycles) * clk_period_ns;
		#(limit_ns);
		$display("Watchdog timeout: the run did not finish within %0d ns", limit_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- rv_exec_top.sv
/*
 * Top level of the RISC-V integer execute slice.
 * A Wishbone classic slave gives the host access to the register file,
 * to single-instruction execution and to the performance counters.
 */
`timescale 1ns/1ps

module rv_exec_top #(
	parameter int xlen = 64
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  exec_bus_pkg::adr_t wb_adr,
	input  logic [xlen-1:0]    wb_dat_i,
	output logic [xlen-1:0]    wb_dat_o,
	output logic               wb_ack,
	output logic               wb_err
);

	rv_isa_pkg::instr_u instr;
	logic [xlen-1:0]    alu_result;
	logic               alu_illegal;
	logic               retire;
	logic               clear;
	logic [xlen-1:0]    retired;
	logic [xlen-1:0]    cycles;

	regfile_if #(.xlen(xlen)) rf_bus ();

	int_regfile #(.xlen(xlen)) i_int_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.rf     (rf_bus.rf)
	);

	int_alu #(.xlen(xlen)) i_int_alu (
		.instr   (instr),
		.rs1_val (rf_bus.rdata1),
		.rs2_val (rf_bus.rdata2),
		.result  (alu_result),
		.illegal (alu_illegal)
	);

	perf_counters #(.xlen(xlen)) i_perf_counters (
		.clk     (clk),
		.arst_n  (arst_n),
		.retire  (retire),
		.clear   (clear),
		.retired (retired),
		.cycles  (cycles)
	);

	exec_sequencer #(.xlen(xlen)) i_exec_sequencer (
		.clk         (clk),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.wb_err      (wb_err),
		.rf          (rf_bus.ctrl),
		.instr       (instr),
		.alu_result  (alu_result),
		.alu_illegal (alu_illegal),
		.retire      (retire),
		.clear       (clear),
		.retired     (retired),
		.cycles      (cycles)
	);

endmodule

//--- rv_exec_vectors.txt
# name    op adr    data              expect
# op w writes and wants ack, r reads and compares, e wants err (a read when data is -).
# data r is a random word; expect m uses the model, g a cycle count above the last, - none.
# An address range lo-hi repeats the line for each address in it.
regs      w  01-1f  r                 -
regs      w  00     5a5a5a5a5a5a5a5a  -
regs      r  00-1f  -                 m
regs      r  00     -                 0
rand_ops  w  20     00418eb3          -
rand_ops  w  20     0041af33          -
rand_ops  w  20     4041dfb3          -
rand_ops  r  1d-1f  -                 m
rr_ops    w  01     80000000000000f5  -
rr_ops    w  02     000000000000004a  -
rr_ops    w  20     00208533          -
rr_ops    w  20     401105b3          -
rr_ops    w  20     00209633          -
rr_ops    w  20     0020a6b3          -
rr_ops    w  20     0020b733          -
rr_ops    w  20     0020c7b3          -
rr_ops    w  20     0020d833          -
rr_ops    w  20     4020d8b3          -
rr_ops    w  20     0020e933          -
rr_ops    w  20     0020f9b3          -
rr_ops    r  0a     -                 800000000000013f
rr_ops    r  0b     -                 7fffffffffffff55
rr_ops    r  0c     -                 000000000003d400
rr_ops    r  0d     -                 0000000000000001
rr_ops    r  0e     -                 0000000000000000
rr_ops    r  0f     -                 80000000000000bf
rr_ops    r  10     -                 0020000000000000
rr_ops    r  11     -                 ffe0000000000000
rr_ops    r  12     -                 80000000000000ff
rr_ops    r  13     -                 0000000000000040
imm_ops   w  20     ff008a13          -
imm_ops   w  20     fff0aa93          -
imm_ops   w  20     fff0bb13          -
imm_ops   w  20     fff0cb93          -
imm_ops   w  20     8000ec13          -
imm_ops   w  20     7ff0fc93          -
imm_ops   w  20     02809d13          -
imm_ops   w  20     0210dd93          -
imm_ops   w  20     4210de13          -
imm_ops   r  14     -                 80000000000000e5
imm_ops   r  15     -                 0000000000000001
imm_ops   r  16     -                 0000000000000001
imm_ops   r  17     -                 7fffffffffffff0a
imm_ops   r  18     -                 fffffffffffff8f5
imm_ops   r  19     -                 00000000000000f5
imm_ops   r  1a     -                 0000f50000000000
imm_ops   r  1b     -                 0000000040000000
imm_ops   r  1c     -                 ffffffffc0000000
dep       w  20     00700293          -
dep       w  20     00728293          -
dep       r  05     -                 000000000000000e
dep       w  20     00128013          -
dep       r  00     -                 0
illegal   e  20     02208333          -
illegal   e  20     40409313          -
illegal   e  20     0000b303          -
illegal   e  23     -                 -
illegal   e  7f     -                 -
illegal   r  00-1f  -                 m
illegal   r  21     -                 m
counters  r  21     -                 m
counters  r  22     -                 g
counters  r  22     -                 g
counters  w  21     0                 -
counters  r  21     -                 0
counters  w  20     00100093          -
counters  r  21     -                 1

//--- rv_isa_pkg.sv
/*
 * RV64I instruction encodings for the integer execute slice.
 * Gives the R and I views of an instruction word as one packed union,
 * plus the opcode and funct3 values that the ALU accepts.
 */
package rv_isa_pkg;

	typedef logic [4:0] reg_addr_t;  // Integer register index.

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;  // Sign-extended by the ALU.
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_u;

	localparam logic [6:0] op_reg = 7'b0110011;  // OP, register-register.
	localparam logic [6:0] op_imm = 7'b0010011;  // OP-IMM, register-immediate.

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;  // funct7 bit 5 picks SRA.
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

endpackage

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Drives a free-running clock and holds the active-low reset for a set
 * number of rising edges before releasing it.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns    = 10,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;  // Released on an edge, like the rest of the stimulus.
	end

endmodule
